//--- ip_rx.f
rtl/ip_rx_pkg.sv
rtl/byte_stream_if.sv
rtl/ip_hdr_checksum.sv
rtl/ip_hdr_parser.sv
rtl/byte_skid_buffer.sv
rtl/ip_rx.sv
tests/ip_rx_tb.sv

//--- Bender.yml
package:
  name: ip_rx

sources:
  - rtl/ip_rx_pkg.sv
  - rtl/byte_stream_if.sv
  - rtl/ip_hdr_checksum.sv
  - rtl/ip_hdr_parser.sv
  - rtl/byte_skid_buffer.sv
  - rtl/ip_rx.sv
  - target: test
    files:
      - tests/ip_rx_tb.sv

//--- tests/ip_rx_tb.sv
// ipv4 receive parser testbench
// random frames checked against queue model under random back-pressure
`default_nettype none

module ip_rx_tb;
    import ip_rx_pkg::*;

    localparam int period          = 8;
    localparam int frames_per_test = 30;
    localparam int total_frames    = 5 * frames_per_test;
    localparam int watchdog_time   = (total_frames * 200 + 50) * period;

    logic       clk = 1'b0;
    logic       rst;
    logic [7:0] s_data;
    logic       s_valid;
    logic       s_ready;
    logic       s_last;
    logic       s_user;
    logic       m_hdr_valid;
    logic       m_hdr_ready;
    ip_hdr_t    m_hdr;
    logic [7:0] m_data;
    logic       m_valid;
    logic       m_ready;
    logic       m_last;
    logic       m_user;
    logic       busy;
    logic       error_invalid_header;
    logic       error_invalid_checksum;
    logic       error_header_early_termination;

    integer      seed = 84025;
    int          stall_pct = 30;
    int          err_count = 0;
    int          tests_failed = 0;
    int          tests_run = 0;
    logic [7:0]  frame [0:63];
    logic        user [0:63];
    logic [31:0] rnd_ready;
    // model queues with payload entries as {last, user, data}
    ip_hdr_t     hdr_q [$];
    logic [9:0]  pay_q [$];
    int          exp_hdr_err = 0;
    int          exp_sum_err = 0;
    int          exp_early_err = 0;
    int          got_hdr_err = 0;
    int          got_sum_err = 0;
    int          got_early_err = 0;
    logic        hdr_wait = 1'b0;
    ip_hdr_t     held_hdr;
    ip_hdr_t     exp_hdr;
    logic [9:0]  exp_pay;

    ip_rx UUT (.*);

    always #(period / 2) clk = ~clk;

    task automatic report_value(input string name, input logic [159:0] exp,
                                input logic [159:0] got);
        $display("ERROR %0t %s expected %0h got %0h", $time, name, exp, got);
        err_count++;
    endtask

    task automatic report_fault(input string msg);
        $display("ERROR %0t %s", $time, msg);
        err_count++;
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    // m_ready low about stall_pct percent of cycles
    always @(posedge clk) begin
        #1;
        rnd_ready   = $random(seed);
        m_ready     = (rnd_ready % 100) >= stall_pct;
        m_hdr_ready = rnd_ready[31];
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (hdr_wait && !m_hdr_valid) report_fault("m_hdr_valid dropped before m_hdr_ready");
            if (hdr_wait && m_hdr !== held_hdr) report_value("m_hdr (held)", held_hdr, m_hdr);
            if (m_hdr_valid && m_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    report_fault("a header came out that the model did not expect");
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    if (m_hdr !== exp_hdr) report_value("m_hdr", exp_hdr, m_hdr);
                end
            end
            hdr_wait = m_hdr_valid && !m_hdr_ready;
            held_hdr = m_hdr;
            if (m_valid && m_ready) begin
                if (pay_q.size() == 0) begin
                    report_fault("a payload byte came out that the model did not expect");
                end else begin
                    exp_pay = pay_q.pop_front();
                    if (m_data !== exp_pay[7:0]) report_value("m_data", exp_pay[7:0], m_data);
                    if (m_user !== exp_pay[8]) report_value("m_user", exp_pay[8], m_user);
                    if (m_last !== exp_pay[9]) report_value("m_last", exp_pay[9], m_last);
                end
            end
            if (error_invalid_header) got_hdr_err++;
            if (error_invalid_checksum) got_sum_err++;
            if (error_header_early_termination) got_early_err++;
        end
    end

    task automatic put_header(input ip_hdr_t h);
        int i;
        frame[0]  = {h.version, h.ihl};
        frame[1]  = {h.dscp, h.ecn};
        frame[2]  = h.length[15:8];
        frame[3]  = h.length[7:0];
        frame[4]  = h.identification[15:8];
        frame[5]  = h.identification[7:0];
        frame[6]  = {h.flags, h.fragment_offset[12:8]};
        frame[7]  = h.fragment_offset[7:0];
        frame[8]  = h.ttl;
        frame[9]  = h.protocol;
        frame[10] = h.header_checksum[15:8];
        frame[11] = h.header_checksum[7:0];
        for (i = 0; i < 4; i++) begin
            frame[12 + i] = h.source_ip[31 - 8 * i -: 8];
            frame[16 + i] = h.dest_ip[31 - 8 * i -: 8];
        end
    endtask

    // one's-complement sum of the ten header words
    function automatic logic [15:0] ones_sum();
        logic [16:0] acc;
        int          i;
        acc = '0;
        for (i = 0; i < 20; i += 2) begin
            acc = acc[15:0] + {frame[i], frame[i + 1]};
            acc = acc[15:0] + acc[16];
        end
        return acc[15:0];
    endfunction

    // kind 0 good, 1 bad version or ihl, 2 bad checksum, 3 early end
    task automatic build_frame(input int kind, output int len);
        ip_hdr_t h;
        int      i;
        for (i = 0; i < 5; i++) h[32 * i +: 32] = $random(seed);
        h.version         = ip_version_v4;
        h.ihl             = ip_ihl_min;
        h.header_checksum = '0;
        if (kind == 1 && rand_below(2) == 0) begin
            h.version = rand_below(16);
            if (h.version == ip_version_v4) h.version = 4'd6;
        end else if (kind == 1) begin
            h.ihl = rand_below(16);
            if (h.ihl == ip_ihl_min) h.ihl = 4'd6;
        end
        put_header(h);
        h.header_checksum = ~ones_sum();
        if (kind == 2) begin
            i = rand_below(16);
            h.header_checksum[i] = ~h.header_checksum[i];
        end
        put_header(h);
        len = (kind == 3) ? 1 + rand_below(20) : 21 + rand_below(40);
        for (i = 0; i < len; i++) begin
            if (i >= 20) frame[i] = $random(seed);
            user[i] = rand_below(2);
        end
        case (kind)
            0: begin
                hdr_q.push_back(h);
                for (i = 20; i < len; i++) pay_q.push_back({i == len - 1, user[i], frame[i]});
            end
            1: exp_hdr_err++;
            2: exp_sum_err++;
            default: exp_early_err++;
        endcase
    endtask

    // starts and ends one time unit after a rising edge
    task automatic send_frame(input int len);
        int   i;
        logic taken;
        for (i = 0; i < len; i++) begin
            while (rand_below(4) == 0) begin
                @(posedge clk);
                #1;
            end
            s_data  = frame[i];
            s_user  = user[i];
            s_last  = (i == len - 1);
            s_valid = 1'b1;
            taken   = 1'b0;
            // s_ready comes from flops and holds through the cycle
            while (!taken) begin
                taken = s_ready;
                @(posedge clk);
                #1;
            end
            s_valid = 1'b0;
            // frame in progress until the byte with last
            if (busy !== (i != len - 1)) report_value("busy", i != len - 1, busy);
        end
    endtask

    task automatic check_outputs_low(input logic exp_s_ready);
        if (s_ready !== exp_s_ready) report_value("s_ready", exp_s_ready, s_ready);
        if (m_hdr_valid !== 1'b0) report_value("m_hdr_valid", 1'b0, m_hdr_valid);
        if (m_valid !== 1'b0) report_value("m_valid", 1'b0, m_valid);
        if (busy !== 1'b0) report_value("busy", 1'b0, busy);
        if (error_invalid_header !== 1'b0)
            report_value("error_invalid_header", 1'b0, error_invalid_header);
        if (error_invalid_checksum !== 1'b0)
            report_value("error_invalid_checksum", 1'b0, error_invalid_checksum);
        if (error_header_early_termination !== 1'b0)
            report_value("error_header_early_termination", 1'b0,
                         error_header_early_termination);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) tests_failed++;
        $display("test %s: %s, %0d errors", name,
                 (err_count == errs_before) ? "ok" : "failed", err_count - errs_before);
    endtask

    task automatic run_frames(input string name, input int kind_sel, input int pct);
        int f;
        int len;
        int errs_before;
        errs_before = err_count;
        stall_pct   = pct;
        for (f = 0; f < frames_per_test; f++) begin
            build_frame((kind_sel < 0) ? rand_below(4) : kind_sel, len);
            send_frame(len);
        end
        while (hdr_q.size() != 0 || pay_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        check_outputs_low(1'b1);
        if (got_hdr_err != exp_hdr_err)
            report_value("invalid header count", exp_hdr_err, got_hdr_err);
        if (got_sum_err != exp_sum_err) report_value("checksum count", exp_sum_err, got_sum_err);
        if (got_early_err != exp_early_err)
            report_value("early termination count", exp_early_err, got_early_err);
        finish_test(name, errs_before);
    endtask

    initial begin
        #(watchdog_time);
        $display("watchdog expired, the frames did not all get through in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        s_data      = '0;
        s_valid     = 1'b0;
        s_last      = 1'b0;
        s_user      = 1'b0;
        m_ready     = 1'b0;
        m_hdr_ready = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check_outputs_low(1'b0);
        end
        rst = 1'b0;
        @(posedge clk);
        #1;
        check_outputs_low(1'b1);
        finish_test("reset and idle", 0);
        run_frames("good frames", 0, 30);
        run_frames("bad version or ihl", 1, 30);
        run_frames("bad checksum", 2, 30);
        run_frames("early termination", 3, 30);
        run_frames("mixed frames under back-pressure", -1, 60);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/ip_rx.sv
// ipv4 receive parser top level
// header capture and checks, checksum and payload output stage
`default_nettype none

module ip_rx (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         s_data,
    input  logic               s_valid,
    output logic               s_ready,
    input  logic               s_last,
    input  logic               s_user,
    output logic               m_hdr_valid,
    input  logic               m_hdr_ready,
    output ip_rx_pkg::ip_hdr_t m_hdr,
    output logic [7:0]         m_data,
    output logic               m_valid,
    input  logic               m_ready,
    output logic               m_last,
    output logic               m_user,
    output logic               busy,
    output logic               error_invalid_header,
    output logic               error_invalid_checksum,
    output logic               error_header_early_termination
);

    logic sum_clear;
    logic sum_add;
    logic sum_ok;

    byte_stream_if pay_if ();

    ip_hdr_parser u_parser (
        .clk                            (clk),
        .rst                            (rst),
        .s_data                         (s_data),
        .s_valid                        (s_valid),
        .s_ready                        (s_ready),
        .s_last                         (s_last),
        .s_user                         (s_user),
        .hdr_valid                      (m_hdr_valid),
        .hdr_ready                      (m_hdr_ready),
        .hdr                            (m_hdr),
        .sum_clear                      (sum_clear),
        .sum_add                        (sum_add),
        .sum_ok                         (sum_ok),
        .pay                            (pay_if.source),
        .busy                           (busy),
        .error_invalid_header           (error_invalid_header),
        .error_invalid_checksum         (error_invalid_checksum),
        .error_header_early_termination (error_header_early_termination)
    );

    ip_hdr_checksum u_checksum (
        .clk    (clk),
        .clear  (sum_clear),
        .add    (sum_add),
        .data   (s_data),
        .sum_ok (sum_ok)
    );

    byte_skid_buffer u_skid (
        .clk     (clk),
        .rst     (rst),
        .s       (pay_if.sink),
        .m_data  (m_data),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_last  (m_last),
        .m_user  (m_user)
    );

endmodule

`default_nettype wire

//--- rtl/byte_skid_buffer.sv
// registered skid buffer for the payload byte stream
// output register plus one spare entry, ready comes from a flop
`default_nettype none

module byte_skid_buffer (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.sink s,
    output logic [7:0]  m_data,
    output logic        m_valid,
    input  logic        m_ready,
    output logic        m_last,
    output logic        m_user
);

    logic       ready_reg;
    logic       m_valid_next;
    logic [7:0] temp_data;
    logic       temp_valid;
    logic       temp_valid_next;
    logic       temp_last;
    logic       temp_user;
    logic       in_to_out;
    logic       in_to_temp;
    logic       temp_to_out;

    assign s.ready = ready_reg;

    always_comb begin
        m_valid_next    = m_valid;
        temp_valid_next = temp_valid;
        in_to_out       = 1'b0;
        in_to_temp      = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_reg) begin
            if (m_ready || !m_valid) begin
                m_valid_next = s.valid;
                in_to_out    = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_valid_next = s.valid;
                in_to_temp      = 1'b1;
            end
        end else if (m_ready) begin
            m_valid_next    = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid    <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            m_valid    <= m_valid_next;
            temp_valid <= temp_valid_next;
            // accept only with room in the spare entry
            ready_reg  <= !temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_data <= s.data;
            m_last <= s.last;
            m_user <= s.user;
        end else if (temp_to_out) begin
            m_data <= temp_data;
            m_last <= temp_last;
            m_user <= temp_user;
        end
        if (in_to_temp) begin
            temp_data <= s.data;
            temp_last <= s.last;
            temp_user <= s.user;
        end
    end

    temp_behind_out_a: assert property (@(posedge clk) disable iff (rst)
        temp_valid |-> m_valid);

endmodule

`default_nettype wire

//--- rtl/ip_hdr_parser.sv
// ipv4 header parser
// captures and checks the fixed header, then steers payload bytes downstream
`default_nettype none

module ip_hdr_parser (
    input  logic               clk,
    input  logic               rst,
    input  logic [7:0]         s_data,
    input  logic               s_valid,
    output logic               s_ready,
    input  logic               s_last,
    input  logic               s_user,
    output logic               hdr_valid,
    input  logic               hdr_ready,
    output ip_rx_pkg::ip_hdr_t hdr,
    output logic               sum_clear,
    output logic               sum_add,
    input  logic               sum_ok,
    byte_stream_if.source      pay,
    output logic               busy,
    output logic               error_invalid_header,
    output logic               error_invalid_checksum,
    output logic               error_header_early_termination
);
    import ip_rx_pkg::*;

    localparam int unsigned hdr_msb = $bits(ip_hdr_t) - 1;

    parser_state_t state;
    parser_state_t state_next;
    logic [4:0]    hdr_ptr;
    logic [4:0]    hdr_ptr_next;
    logic          s_ready_reg;
    logic          s_ready_next;
    logic          hdr_valid_next;
    logic          err_hdr_next;
    logic          err_sum_next;
    logic          err_early_next;
    logic          store_byte;
    logic          in_xfer;
    logic          hdr_phase;

    // payload phase takes ready straight from the skid buffer register
    assign s_ready   = (state == read_payload) ? pay.ready : s_ready_reg;
    assign in_xfer   = s_valid && s_ready;
    assign hdr_phase = (state == idle) || (state == read_header);

    // the closing byte is never summed, so the sum restarts clean
    assign sum_add   = in_xfer && hdr_phase && !s_last;
    assign sum_clear = !sum_add && ((state == idle) || (in_xfer && s_last));

    assign pay.valid = (state == read_payload) && s_valid;
    assign pay.data  = s_data;
    assign pay.last  = s_last;
    assign pay.user  = s_user;

    always_comb begin
        state_next     = state;
        hdr_ptr_next   = hdr_ptr;
        s_ready_next   = 1'b0;
        hdr_valid_next = hdr_valid && !hdr_ready;
        err_hdr_next   = 1'b0;
        err_sum_next   = 1'b0;
        err_early_next = 1'b0;
        store_byte     = 1'b0;

        case (state)
            idle: begin
                // no new frame while a header is still waiting
                hdr_ptr_next = '0;
                s_ready_next = !hdr_valid_next;
                if (in_xfer) begin
                    store_byte = 1'b1;
                    if (s_last) begin
                        err_early_next = 1'b1;
                    end else begin
                        hdr_ptr_next = 5'd1;
                        s_ready_next = 1'b1;
                        state_next   = read_header;
                    end
                end
            end
            read_header: begin
                s_ready_next = 1'b1;
                if (in_xfer) begin
                    store_byte   = 1'b1;
                    hdr_ptr_next = hdr_ptr + 5'd1;
                    if (s_last) begin
                        err_early_next = 1'b1;
                        hdr_ptr_next   = '0;
                        s_ready_next   = !hdr_valid_next;
                        state_next     = idle;
                    end else if (hdr_ptr == ip_hdr_bytes - 5'd1) begin
                        hdr_ptr_next = '0;
                        if (hdr.version != ip_version_v4 || hdr.ihl != ip_ihl_min) begin
                            err_hdr_next = 1'b1;
                            state_next   = drop;
                        end else if (!sum_ok) begin
                            err_sum_next = 1'b1;
                            state_next   = drop;
                        end else begin
                            hdr_valid_next = 1'b1;
                            state_next     = read_payload;
                        end
                    end
                end
            end
            read_payload: begin
                if (in_xfer && s_last) begin
                    s_ready_next = !hdr_valid_next;
                    state_next   = idle;
                end
            end
            drop: begin
                // discard the rest of a rejected frame
                s_ready_next = 1'b1;
                if (in_xfer && s_last) begin
                    s_ready_next = !hdr_valid_next;
                    state_next   = idle;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                          <= idle;
            hdr_ptr                        <= '0;
            s_ready_reg                    <= 1'b0;
            hdr_valid                      <= 1'b0;
            busy                           <= 1'b0;
            error_invalid_header           <= 1'b0;
            error_invalid_checksum         <= 1'b0;
            error_header_early_termination <= 1'b0;
        end else begin
            state                          <= state_next;
            hdr_ptr                        <= hdr_ptr_next;
            s_ready_reg                    <= s_ready_next;
            hdr_valid                      <= hdr_valid_next;
            busy                           <= (state_next != idle);
            error_invalid_header           <= err_hdr_next;
            error_invalid_checksum         <= err_sum_next;
            error_header_early_termination <= err_early_next;
        end
    end

    // header bytes land msb first
    always_ff @(posedge clk) begin
        if (store_byte) begin
            hdr[hdr_msb - 8 * hdr_ptr -: 8] <= s_data;
        end
    end

    hdr_stable_a: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> $stable(hdr));

    hdr_ptr_range_a: assert property (@(posedge clk) disable iff (rst)
        state == read_header |-> hdr_ptr < ip_hdr_bytes);

endmodule

`default_nettype wire

//--- rtl/ip_hdr_checksum.sv
// ipv4 header checksum accumulator
// 16-bit one's-complement sum built from a byte stream
`default_nettype none

module ip_hdr_checksum (
    input  logic       clk,
    input  logic       clear,
    input  logic       add,
    input  logic [7:0] data,
    output logic       sum_ok
);
    import ip_rx_pkg::*;

    logic [15:0] sum;
    logic        odd;
    logic [15:0] addend;
    logic [16:0] sum_wide;
    logic [15:0] sum_next;

    // even bytes are the high half of a 16-bit word
    assign addend   = odd ? {8'h00, data} : {data, 8'h00};
    assign sum_wide = {1'b0, sum} + {1'b0, addend};
    // end-around carry
    assign sum_next = sum_wide[15:0] + {15'd0, sum_wide[16]};
    assign sum_ok   = (sum_next == ip_sum_good);

    always_ff @(posedge clk) begin
        if (clear) begin
            sum <= '0;
            odd <= 1'b0;
        end else if (add) begin
            sum <= sum_next;
            odd <= ~odd;
        end
    end

    clear_add_excl_a: assert property (@(posedge clk) add |-> !clear);

endmodule

`default_nettype wire

//--- rtl/byte_stream_if.sv
// byte stream link with valid/ready handshake
// carries one payload byte plus frame end and user flag
`default_nettype none

interface byte_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       last;
    logic       user;

    modport source (output data, valid, last, user, input ready);

    modport sink (input data, valid, last, user, output ready);

endinterface

`default_nettype wire

//--- rtl/ip_rx_pkg.sv
// ipv4 receive parser shared definitions
// protocol constants, header layout and parser state encoding
`default_nettype none

package ip_rx_pkg;

    // fixed 20-byte header, no options
    localparam logic [4:0]  ip_hdr_bytes  = 5'd20;
    localparam logic [3:0]  ip_version_v4 = 4'd4;
    localparam logic [3:0]  ip_ihl_min    = 4'd5;
    // one's-complement sum over a correct header
    localparam logic [15:0] ip_sum_good   = 16'hffff;

    // wire order, first byte in the top bits
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    typedef enum logic [1:0] {
        idle,
        read_header,
        read_payload,
        drop
    } parser_state_t;

endpackage

`default_nettype wire
